// ==== sources.f ====
+incdir+logic
logic/memStagePkg.sv
logic/pipeReg.sv
logic/memAccess.sv
logic/exceptionUnit.sv
logic/memStage.sv
test/tbClockGen.sv
test/memStageTb.sv

// ==== test/memStageTb.sv ====
//==========================================================================
// Lockstep check of the MEM stage. A model of both pipeline registers and
// the data memory is compared with the DUT at every falling edge.
//==========================================================================

`timescale 1ns/10ps
`default_nettype none
`include "memStage_macros.svh"

module memStageTb
    import memStagePkg::*;
();

    logic        clk, arstN, memFlush, memWr, idFlush, exFlush, memFlushOut, isExc;
    logic [31:0] cp0Status, cp0Cause, cp0Epc, eretEpc, memResult, pcCnt;
    logic [4:0]  memDst;
    exMemT       exIn;
    exMemT       exModel;                  // Mirrors MEM.
    memWbT       wbOut;
    memWbT       wbModel;                  // Mirrors WB.
    logic [31:0] refMem [`DMEM_WORDS];
    int          errCount, checkCount, testCount, errBase, waitCnt;

    tbClockGen clkGen (.clk_o(clk), .arstN_o(arstN));

    memStage dut (
        .clk_i(clk), .arstN_i(arstN), .memFlush_i(memFlush), .memWr_i(memWr),
        .cp0Status_i(cp0Status), .cp0Cause_i(cp0Cause), .cp0Epc_i(cp0Epc),
        .exIn_i(exIn), .wbOut_o(wbOut), .idFlush_o(idFlush), .exFlush_o(exFlush),
        .memFlush_o(memFlushOut), .isExcOrEret_o(isExc), .eretEpc_o(eretEpc),
        .memDst_o(memDst), .memResult_o(memResult)
    );

    function automatic logic [31:0] bypassCp0(input logic [4:0]  num,
                                              input logic [31:0] committed);
        return (wbModel.regWr.cp0Wr && wbModel.dst == num) ? wbModel.outB : committed;
    endfunction

    // Expected WB payload for the instruction now in MEM.
    function automatic memWbT expectWb(input exMemT p);
        memWbT       r;
        logic [31:0] word;
        logic [31:0] st;
        logic [31:0] ca;
        logic [7:0]  lane;
        logic [15:0] half;
        logic [1:0]  align;
        excCodeT     fault;
        r     = '0;
        word  = refMem[(p.aluOut >> 2) % `DMEM_WORDS];
        lane  = word[8 * int'(p.aluOut[1:0]) +: 8];
        half  = word[16 * int'(p.aluOut[1]) +: 16];
        st    = bypassCp0(`CP0_STATUS, cp0Status);
        ca    = bypassCp0(`CP0_CAUSE, cp0Cause);
        case (p.loadType)
            LD_LB:   r.loadData = 32'($signed(lane));
            LD_LBU:  r.loadData = 32'(lane);
            LD_LH:   r.loadData = 32'($signed(half));
            LD_LHU:  r.loadData = 32'(half);
            LD_LW:   r.loadData = word;
            default: r.loadData = '0;
        endcase
        align = 2'b00;                     // Address bits that must be zero.
        if (p.loadType == LD_LH || p.loadType == LD_LHU || p.storeType == ST_SH) begin
            align = 2'b01;
        end else if (p.loadType == LD_LW || p.storeType == ST_SW) begin
            align = 2'b11;
        end
        fault = EXC_NONE;
        if ((p.aluOut[1:0] & align) != 2'b00) begin
            fault = EXC_ADES;
            if (p.loadType != LD_NONE) begin
                fault = EXC_ADEL;
            end
        end
        r.excCode = EXC_NONE;
        if (p.pc != 32'd0 && st[`STATUS_IE] && !st[`STATUS_EXL] &&
            (st[`IM_LSB +: 8] & ca[`IP_LSB +: 8]) != 8'd0) begin
            r.excCode = EXC_INT;
        end else if (p.excFlags.fetchAdel) begin
            r.excCode  = EXC_ADEL;
            r.badVaddr = p.pc;
        end else if (p.excFlags.reserved) begin
            r.excCode = EXC_RI;
        end else if (p.excFlags.overflow) begin
            r.excCode = EXC_OV;
        end else if (p.excFlags.syscall) begin
            r.excCode = EXC_SYS;
        end else if (p.excFlags.brk) begin
            r.excCode = EXC_BP;
        end else if (fault != EXC_NONE) begin
            r.excCode  = fault;
            r.badVaddr = p.aluOut;
        end
        r.pc       = p.pc;
        r.aluOut   = p.aluOut;
        r.outB     = p.outB;
        r.dst      = p.dst;
        r.wbSel    = p.wbSel;
        r.isBranch = p.isBranch;
        r.excEpc   = wbModel.isBranch ? p.pc - 32'd4 : p.pc;  // Delay slot.
        if (r.excCode == EXC_NONE && !p.excFlags.eret) begin
            r.regWr = p.regWr;
        end
        return r;
    endfunction

    task automatic checkVal(input string name, input logic [$bits(memWbT)-1:0] got,
                            input logic [$bits(memWbT)-1:0] exp);
        checkCount++;
        assert (got === exp) else begin
            errCount++;
            $display("Error at %0t ns: %s expected %0h, got %0h", $time, name, exp, got);
        end
    endtask

    // Compare mid-cycle, then advance the model by one rising edge.
    always @(negedge clk) begin : compare
        memWbT expWb;
        logic  excExp;
        int    idx;
        if (!arstN) begin
            exModel = '0;
            wbModel = '0;
            foreach (refMem[i])
                refMem[i] = '0;
        end else begin
            expWb  = expectWb(exModel);
            excExp = expWb.excCode != EXC_NONE || exModel.excFlags.eret;
            idx    = (exModel.aluOut >> 2) % `DMEM_WORDS;
            checkVal("wbOut_o", wbOut, wbModel);
            checkVal("memDst_o", memDst, exModel.dst);
            checkVal("memResult_o", memResult,
                     (exModel.wbSel == WB_OUTB) ? exModel.outB : exModel.aluOut);
            checkVal("{idFlush_o,exFlush_o,memFlush_o,isExcOrEret_o}",
                     {idFlush, exFlush, memFlushOut, isExc}, {4{excExp}});
            checkVal("eretEpc_o", eretEpc, bypassCp0(`CP0_EPC, cp0Epc));
            if (memWr && !excExp) begin
                case (exModel.storeType)
                    ST_SB: refMem[idx][8 * int'(exModel.aluOut[1:0]) +: 8] = exModel.outB[7:0];
                    ST_SH: refMem[idx][16 * int'(exModel.aluOut[1]) +: 16] = exModel.outB[15:0];
                    ST_SW: refMem[idx] = exModel.outB;
                    default: ;
                endcase
            end
            if (memWr) begin
                wbModel = expWb;
            end else begin
                wbModel = '0;                  // Stall bubble.
            end
            if (memFlush) begin
                exModel = '0;
            end else if (memWr) begin
                exModel = exIn;
            end
        end
    end

    task automatic drive(input exMemT p, input logic wr, input logic fl);
        @(posedge clk);
        #0.5;
        exIn     = p;
        memWr    = wr;
        memFlush = fl;
    endtask

    function automatic exMemT mkOp(input logic [31:0] addr, input logic [31:0] data,
                                   input loadTypeT lt, input storeTypeT st, input wbSelT ws);
        exMemT p;
        pcCnt         = pcCnt + 32'd4;
        p             = '0;
        p.pc          = pcCnt;
        p.instr       = $urandom;
        p.aluOut      = addr;
        p.outB        = data;
        p.dst         = 5'($urandom % 31 + 1);
        p.loadType    = lt;
        p.storeType   = st;
        p.wbSel       = ws;
        p.regWr.gprWr = (st == ST_NONE);
        return p;
    endfunction

    task automatic finishTest(input string name);
        repeat (3)
            drive('0, 1'b1, 1'b0);            // Drain both registers.
        testCount++;
        $display("Test %0d %s: %s, %0d errors", testCount, name,
                 (errCount == errBase) ? "passed" : "failed", errCount - errBase);
        errBase = errCount;
    endtask

    task automatic runTests();
        logic [31:0] a;
        exMemT       op;
        int          i;
        logic [31:0] statusList [4] = '{32'h401, 32'h403, 32'h400, 32'h801};
        for (i = 0; i < 6; i++) begin
            a = $urandom & 32'hFFFF_FFFC;
            drive(mkOp(a, $urandom, LD_NONE, ST_SW, WB_ALU), 1'b1, 1'b0);
            drive(mkOp(a + $urandom % 4, $urandom, LD_NONE, ST_SB, WB_ALU), 1'b1, 1'b0);
            drive(mkOp(a + 2 * ($urandom % 2), $urandom, LD_NONE, ST_SH, WB_ALU), 1'b1, 1'b0);
            drive(mkOp(a + $urandom % 4, 0, LD_LB, ST_NONE, WB_LOAD), 1'b1, 1'b0);
            drive(mkOp(a + $urandom % 4, 0, LD_LBU, ST_NONE, WB_LOAD), 1'b1, 1'b0);
            drive(mkOp(a + 2 * ($urandom % 2), 0, LD_LH, ST_NONE, WB_LOAD), 1'b1, 1'b0);
            drive(mkOp(a + 2 * ($urandom % 2), 0, LD_LHU, ST_NONE, WB_LOAD), 1'b1, 1'b0);
            drive(mkOp(a, 0, LD_LW, ST_NONE, WB_LOAD), 1'b1, 1'b0);
        end
        finishTest("store and load");
        for (i = 0; i < 8; i++) begin
            drive(mkOp($urandom, $urandom, LD_NONE, ST_NONE, wbSelT'(i % 2)), 1'b1, 1'b0);
        end
        finishTest("forwarding");
        a = $urandom & 32'hFFFF_FFFC;
        drive(mkOp(a, $urandom, LD_NONE, ST_SW, WB_ALU), 1'b1, 1'b0);
        drive(mkOp(a + 1, 0, LD_LH, ST_NONE, WB_LOAD), 1'b1, 1'b0);
        drive(mkOp(a + 3, 0, LD_LHU, ST_NONE, WB_LOAD), 1'b1, 1'b0);
        drive(mkOp(a + 2, 0, LD_LW, ST_NONE, WB_LOAD), 1'b1, 1'b0);
        drive(mkOp(a + 1, $urandom, LD_NONE, ST_SH, WB_ALU), 1'b1, 1'b0);
        drive(mkOp(a + 2, $urandom, LD_NONE, ST_SW, WB_ALU), 1'b1, 1'b0);
        drive(mkOp(a, 0, LD_LW, ST_NONE, WB_LOAD), 1'b1, 1'b0);  // Word must be unchanged.
        finishTest("alignment faults");
        for (i = 0; i < 10; i++) begin
            op          = mkOp($urandom, 0, LD_LW, ST_NONE, WB_LOAD);
            op.excFlags = 6'($urandom) & 6'b111110;
            drive(op, 1'b1, 1'b0);
        end
        cp0Cause = 32'h0000_0400;              // IP2 pending.
        for (i = 0; i < 4; i++) begin
            cp0Status = statusList[i];
            drive('0, 1'b1, 1'b0);             // A bubble never takes the interrupt.
            drive(mkOp($urandom, $urandom, LD_NONE, ST_NONE, WB_ALU), 1'b1, 1'b0);
            drive(mkOp($urandom, $urandom, LD_NONE, ST_NONE, WB_ALU), 1'b1, 1'b0);
        end
        {cp0Status, cp0Cause} = '0;
        op          = mkOp($urandom, 0, LD_NONE, ST_NONE, WB_ALU);
        op.isBranch = 1'b1;
        drive(op, 1'b1, 1'b0);
        op                  = mkOp($urandom, 0, LD_NONE, ST_NONE, WB_ALU);
        op.excFlags.syscall = 1'b1;
        drive(op, 1'b1, 1'b0);
        finishTest("priority and interrupts");
        cp0Epc          = $urandom;
        op              = mkOp($urandom, 0, LD_NONE, ST_NONE, WB_ALU);
        op.excFlags.eret = 1'b1;
        drive(op, 1'b1, 1'b0);
        op       = mkOp($urandom, $urandom, LD_NONE, ST_NONE, WB_OUTB);  // MTC0 to EPC.
        op.regWr = 2'b01;
        op.dst   = `CP0_EPC;
        drive(op, 1'b1, 1'b0);
        op               = mkOp($urandom, 0, LD_NONE, ST_NONE, WB_ALU);
        op.excFlags.eret = 1'b1;
        drive(op, 1'b1, 1'b0);
        cp0Cause = 32'h0000_0100;
        op       = mkOp($urandom, 32'h0000_0101, LD_NONE, ST_NONE, WB_OUTB);
        op.regWr = 2'b01;
        op.dst   = `CP0_STATUS;
        drive(op, 1'b1, 1'b0);
        drive(mkOp($urandom, 0, LD_NONE, ST_NONE, WB_ALU), 1'b1, 1'b0);
        finishTest("eret and bypass");
        cp0Cause = '0;
        a        = $urandom & 32'hFFFF_FFFC;
        drive(mkOp(a, $urandom, LD_NONE, ST_SW, WB_ALU), 1'b1, 1'b1);
        drive(mkOp(a, 0, LD_LW, ST_NONE, WB_LOAD), 1'b1, 1'b0);
        drive(mkOp(a + 1, $urandom, LD_NONE, ST_SB, WB_ALU), 1'b1, 1'b0);
        drive('0, 1'b0, 1'b0);
        drive('0, 1'b0, 1'b0);
        drive(mkOp(a, 0, LD_LW, ST_NONE, WB_LOAD), 1'b1, 1'b0);
        drive(mkOp(a + 2, $urandom, LD_NONE, ST_SB, WB_ALU), 1'b1, 1'b0);
        drive('0, 1'b0, 1'b1);                 // Stalled store is flushed unwritten.
        drive(mkOp(a, 0, LD_LW, ST_NONE, WB_LOAD), 1'b1, 1'b0);
        finishTest("flush and stall");
    endtask

    initial begin
        void'($urandom(94));
        exIn       = '0;
        memWr      = 1'b1;
        memFlush   = 1'b0;
        cp0Status  = '0;
        cp0Cause   = '0;
        cp0Epc     = '0;
        pcCnt      = 32'h0040_0000;
        errCount   = 0;
        checkCount = 0;
        testCount  = 0;
        errBase    = 0;
        waitCnt    = 0;
        while (!arstN && waitCnt < 20) begin
            @(posedge clk);
            waitCnt++;
        end
        if (!arstN) begin
            $display("Timeout: reset still asserted after %0d cycles", waitCnt);
            $display("RESULT: FAIL");
        end else begin
            runTests();
            $display("Summary: %0d tests, %0d checks, %0d errors",
                     testCount, checkCount, errCount);
            if (errCount == 0) begin
                $display("RESULT: PASS");
            end else begin
                $display("RESULT: FAIL");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/tbClockGen.sv ====
//==========================================================================
// Clock with a 4 ns period; active-low reset held for 8 rising edges.
//==========================================================================

`timescale 1ns/10ps
`default_nettype none

module tbClockGen (
    output logic clk_o,
    output logic arstN_o
);

    initial begin
        clk_o   = 1'b0;
        arstN_o = 1'b0;
        forever begin
            #2 clk_o = ~clk_o;
        end
    end

    initial begin
        repeat (8) @(posedge clk_o);
        #0.5 arstN_o = 1'b1;             // Released off the edge.
    end

endmodule

`default_nettype wire

// ==== logic/memStage.sv ====
//==========================================================================
// MEM stage of the pipeline. Load data is not forwarded: load-use hazards
// are stalled upstream. memWr_i low stalls and sends a bubble to WB.
//==========================================================================

`timescale 1ns/10ps
`default_nettype none

module memStage
    import memStagePkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        arstN_i,
    input  wire logic        memFlush_i,
    input  wire logic        memWr_i,
    input  wire logic [31:0] cp0Status_i,
    input  wire logic [31:0] cp0Cause_i,
    input  wire logic [31:0] cp0Epc_i,
    input  wire exMemT       exIn_i,
    output memWbT            wbOut_o,
    output logic             idFlush_o,
    output logic             exFlush_o,
    output logic             memFlush_o,
    output logic             isExcOrEret_o,
    output logic [31:0]      eretEpc_o,
    output logic [4:0]       memDst_o,     // Forwarding destination.
    output logic [31:0]      memResult_o   // Forwarding data.
);

    exMemT       memQ;
    memWbT       memWbD;
    memWbT       wbQ;
    logic [31:0] loadData;
    excCodeT     memFault;
    regWrT       finalRegWr;
    excCodeT     excCode;
    logic [31:0] excEpc;
    logic [31:0] badVaddr;
    logic        storeOk;
    logic        storeEn;

    pipeReg #(
        .payloadT (exMemT)
    ) exMemReg (
        .clk_i   (clk_i),
        .arstN_i (arstN_i),
        .wrEn_i  (memWr_i),
        .flush_i (memFlush_i),
        .d_i     (exIn_i),
        .q_o     (memQ)
    );

    // A stall or an exception suppresses the store.
    assign storeEn = storeOk && memWr_i;

    memAccess memAccessU (
        .clk_i       (clk_i),
        .arstN_i     (arstN_i),
        .addr_i      (memQ.aluOut),
        .storeData_i (memQ.outB),
        .loadType_i  (memQ.loadType),
        .storeType_i (memQ.storeType),
        .storeEn_i   (storeEn),
        .loadData_o  (loadData),
        .fault_o     (memFault)
    );

    exceptionUnit exceptionUnitU (
        .memPc_i       (memQ.pc),
        .memAddr_i     (memQ.aluOut),
        .excFlags_i    (memQ.excFlags),
        .memFault_i    (memFault),
        .regWr_i       (memQ.regWr),
        .wbIsBranch_i  (wbQ.isBranch),
        .wbCp0Wr_i     (wbQ.regWr.cp0Wr),
        .wbCp0Addr_i   (wbQ.dst),        // CP0 number rides in dst.
        .wbCp0Data_i   (wbQ.outB),
        .cp0Status_i   (cp0Status_i),
        .cp0Cause_i    (cp0Cause_i),
        .cp0Epc_i      (cp0Epc_i),
        .regWr_o       (finalRegWr),
        .excCode_o     (excCode),
        .excEpc_o      (excEpc),
        .badVaddr_o    (badVaddr),
        .storeOk_o     (storeOk),
        .idFlush_o     (idFlush_o),
        .exFlush_o     (exFlush_o),
        .memFlush_o    (memFlush_o),
        .isExcOrEret_o (isExcOrEret_o),
        .eretEpc_o     (eretEpc_o)
    );

    always_comb begin
        memWbD          = '0;
        memWbD.pc       = memQ.pc;
        memWbD.aluOut   = memQ.aluOut;
        memWbD.outB     = memQ.outB;
        memWbD.loadData = loadData;
        memWbD.dst      = memQ.dst;
        memWbD.wbSel    = memQ.wbSel;
        memWbD.regWr    = finalRegWr;
        memWbD.isBranch = memQ.isBranch;
        memWbD.excCode  = excCode;
        memWbD.excEpc   = excEpc;
        memWbD.badVaddr = badVaddr;
    end

    // Always enabled; the stall flushes it to a bubble.
    pipeReg #(
        .payloadT (memWbT)
    ) memWbReg (
        .clk_i   (clk_i),
        .arstN_i (arstN_i),
        .wrEn_i  (1'b1),
        .flush_i (!memWr_i),
        .d_i     (memWbD),
        .q_o     (wbQ)
    );

    assign wbOut_o = wbQ;

    assign memDst_o    = memQ.dst;
    assign memResult_o = (memQ.wbSel == WB_OUTB) ? memQ.outB : memQ.aluOut;

endmodule

`default_nettype wire

// ==== logic/exceptionUnit.sv ====
//==========================================================================
// Exception arbitration for the instruction in MEM. CP0 inputs are the
// committed values; a CP0 write still in writeback is bypassed here.
//==========================================================================

`timescale 1ns/10ps
`default_nettype none
`include "memStage_macros.svh"

module exceptionUnit
    import memStagePkg::*;
(
    input  wire logic [31:0] memPc_i,
    input  wire logic [31:0] memAddr_i,
    input  wire excFlagsT    excFlags_i,
    input  wire excCodeT     memFault_i,
    input  wire regWrT       regWr_i,
    input  wire logic        wbIsBranch_i,   // MEM instr sits in a delay slot.
    input  wire logic        wbCp0Wr_i,
    input  wire logic [4:0]  wbCp0Addr_i,
    input  wire logic [31:0] wbCp0Data_i,
    input  wire logic [31:0] cp0Status_i,
    input  wire logic [31:0] cp0Cause_i,
    input  wire logic [31:0] cp0Epc_i,
    output regWrT            regWr_o,
    output excCodeT          excCode_o,
    output logic [31:0]      excEpc_o,
    output logic [31:0]      badVaddr_o,
    output logic             storeOk_o,
    output logic             idFlush_o,
    output logic             exFlush_o,
    output logic             memFlush_o,
    output logic             isExcOrEret_o,
    output logic [31:0]      eretEpc_o
);

    logic [31:0] effStatus;
    logic [31:0] effCause;
    logic [31:0] effEpc;
    logic        intTaken;
    logic        isExcOrEret;

    assign effStatus = (wbCp0Wr_i && wbCp0Addr_i == `CP0_STATUS) ? wbCp0Data_i : cp0Status_i;
    assign effCause  = (wbCp0Wr_i && wbCp0Addr_i == `CP0_CAUSE)  ? wbCp0Data_i : cp0Cause_i;
    assign effEpc    = (wbCp0Wr_i && wbCp0Addr_i == `CP0_EPC)    ? wbCp0Data_i : cp0Epc_i;

    // Bubbles carry pc zero and never take an interrupt.
    assign intTaken = effStatus[`STATUS_IE] && !effStatus[`STATUS_EXL] &&
                      |(effStatus[`IM_LSB +: 8] & effCause[`IP_LSB +: 8]) &&
                      (memPc_i != 32'd0);

    // Fixed priority, oldest cause first.
    always_comb begin
        excCode_o  = EXC_NONE;
        badVaddr_o = '0;
        if (intTaken) begin
            excCode_o = EXC_INT;
        end else if (excFlags_i.fetchAdel) begin
            excCode_o  = EXC_ADEL;
            badVaddr_o = memPc_i;        // Fetch address.
        end else if (excFlags_i.reserved) begin
            excCode_o = EXC_RI;
        end else if (excFlags_i.overflow) begin
            excCode_o = EXC_OV;
        end else if (excFlags_i.syscall) begin
            excCode_o = EXC_SYS;
        end else if (excFlags_i.brk) begin
            excCode_o = EXC_BP;
        end else if (memFault_i != EXC_NONE) begin
            excCode_o  = memFault_i;
            badVaddr_o = memAddr_i;      // Data address.
        end
    end

    assign isExcOrEret = (excCode_o != EXC_NONE) || excFlags_i.eret;

    assign excEpc_o = wbIsBranch_i ? memPc_i - 32'd4 : memPc_i;

    assign regWr_o   = isExcOrEret ? '0 : regWr_i;
    assign storeOk_o = !isExcOrEret;

    // Same pulse to every earlier stage.
    assign idFlush_o     = isExcOrEret;
    assign exFlush_o     = isExcOrEret;
    assign memFlush_o    = isExcOrEret;
    assign isExcOrEret_o = isExcOrEret;

    assign eretEpc_o = effEpc;

endmodule

`default_nettype wire

// ==== logic/memAccess.sv ====
//==========================================================================
// Word-array data memory with combinational read. Addresses wrap modulo
// DMEM_WORDS; the caller must gate storeEn_i on faults.
//==========================================================================

`timescale 1ns/10ps
`default_nettype none
`include "memStage_macros.svh"

module memAccess
    import memStagePkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        arstN_i,
    input  wire logic [31:0] addr_i,
    input  wire logic [31:0] storeData_i,
    input  wire loadTypeT    loadType_i,
    input  wire storeTypeT   storeType_i,
    input  wire logic        storeEn_i,
    output logic [31:0]      loadData_o,
    output excCodeT          fault_o
);

    localparam int Depth   = `DMEM_WORDS;
    localparam int IdxBits = $clog2(Depth);

    logic [31:0]        mem [Depth];
    logic [IdxBits-1:0] wordIdx;
    logic [3:0]         byteEn;
    logic [31:0]        wrData;
    logic [31:0]        rdWord;
    logic [7:0]         rdByte;
    logic [15:0]        rdHalf;
    logic               halfMis;
    logic               wordMis;

    assign wordIdx = addr_i[IdxBits+1:2];
    assign halfMis = addr_i[0];
    assign wordMis = |addr_i[1:0];

    // Lane enables with the data replicated onto every lane.
    always_comb begin
        byteEn = 4'b0000;
        wrData = storeData_i;
        unique case (storeType_i)
            ST_SB: begin
                byteEn = 4'b0001 << addr_i[1:0];
                wrData = {4{storeData_i[7:0]}};
            end
            ST_SH: begin
                byteEn = addr_i[1] ? 4'b1100 : 4'b0011;
                wrData = {2{storeData_i[15:0]}};
            end
            ST_SW:   byteEn = 4'b1111;
            default: byteEn = 4'b0000;
        endcase
    end

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            for (int i = 0; i < Depth; i++) begin
                mem[i] <= '0;
            end
        end else if (storeEn_i) begin
            for (int b = 0; b < 4; b++) begin
                if (byteEn[b]) begin
                    mem[wordIdx][8*b +: 8] <= wrData[8*b +: 8];
                end
            end
        end
    end

    assign rdWord = mem[wordIdx];
    assign rdByte = rdWord[{addr_i[1:0], 3'b000} +: 8];
    assign rdHalf = addr_i[1] ? rdWord[31:16] : rdWord[15:0];

    always_comb begin
        unique case (loadType_i)
            LD_LB:   loadData_o = {{24{rdByte[7]}}, rdByte};  // Sign extend.
            LD_LBU:  loadData_o = {24'd0, rdByte};
            LD_LH:   loadData_o = {{16{rdHalf[15]}}, rdHalf};
            LD_LHU:  loadData_o = {16'd0, rdHalf};
            LD_LW:   loadData_o = rdWord;
            default: loadData_o = '0;
        endcase
    end

    // Alignment checks, loads before stores.
    always_comb begin
        fault_o = EXC_NONE;
        if (((loadType_i == LD_LH || loadType_i == LD_LHU) && halfMis) ||
            (loadType_i == LD_LW && wordMis)) begin
            fault_o = EXC_ADEL;
        end else if ((storeType_i == ST_SH && halfMis) ||
                     (storeType_i == ST_SW && wordMis)) begin
            fault_o = EXC_ADES;
        end
    end

endmodule

`default_nettype wire

// ==== logic/pipeReg.sv ====
//==========================================================================
// Pipeline register for any packed payload. Flush beats write enable and
// loads an all-zero bubble.
//==========================================================================

`timescale 1ns/10ps
`default_nettype none

module pipeReg
    import memStagePkg::*;
#(
    parameter type payloadT = exMemT
) (
    input  wire logic    clk_i,
    input  wire logic    arstN_i,
    input  wire logic    wrEn_i,   // Low holds the contents.
    input  wire logic    flush_i,  // Loads a bubble.
    input  wire payloadT d_i,
    output payloadT      q_o
);

    payloadT payloadQ;

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            payloadQ <= '0;
        end else if (flush_i) begin
            payloadQ <= '0;
        end else if (wrEn_i) begin
            payloadQ <= d_i;
        end
    end

    assign q_o = payloadQ;

endmodule

`default_nettype wire

// ==== logic/memStagePkg.sv ====
//==========================================================================
// Types shared by the memory stage and its testbench. An all-zero payload
// is a bubble: no load, no store, no write and no exception.
//==========================================================================

`default_nettype none

package memStagePkg;

    typedef enum logic [2:0] {
        LD_NONE, LD_LB, LD_LBU, LD_LH, LD_LHU, LD_LW
    } loadTypeT;

    typedef enum logic [1:0] {
        ST_NONE, ST_SB, ST_SH, ST_SW
    } storeTypeT;

    typedef enum logic [1:0] {
        WB_ALU, WB_OUTB, WB_LOAD  // Value written back.
    } wbSelT;

    typedef struct packed {
        logic gprWr;
        logic cp0Wr;
    } regWrT;

    // Exceptions flagged by earlier stages.
    typedef struct packed {
        logic fetchAdel;
        logic reserved;
        logic overflow;
        logic syscall;
        logic brk;
        logic eret;
    } excFlagsT;

    typedef enum logic [4:0] {
        EXC_INT  = 5'd0,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5,
        EXC_SYS  = 5'd8,
        EXC_BP   = 5'd9,
        EXC_RI   = 5'd10,
        EXC_OV   = 5'd12,
        EXC_NONE = 5'd31
    } excCodeT;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
        logic [31:0] aluOut;   // Address or ALU result.
        logic [31:0] outB;     // Store data.
        logic [4:0]  dst;
        loadTypeT    loadType;
        storeTypeT   storeType;
        wbSelT       wbSel;
        regWrT       regWr;
        excFlagsT    excFlags;
        logic        isBranch; // Branch or jump.
    } exMemT;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] aluOut;
        logic [31:0] outB;
        logic [31:0] loadData;
        logic [4:0]  dst;
        wbSelT       wbSel;
        regWrT       regWr;    // Already gated by exceptions.
        logic        isBranch;
        excCodeT     excCode;
        logic [31:0] excEpc;
        logic [31:0] badVaddr;
    } memWbT;

endpackage

`default_nettype wire

// ==== logic/memStage_macros.svh ====
//==========================================================================
// Sizes and CP0 field positions for the memory stage. The data memory
// wraps at DMEM_WORDS words; bit positions follow the MIPS32 CP0 layout.
//==========================================================================

`ifndef MEMSTAGE_MACROS_SVH
`define MEMSTAGE_MACROS_SVH

// Data memory depth in 32-bit words.
`define DMEM_WORDS 256

// CP0 register numbers.
`define CP0_STATUS 5'd12
`define CP0_CAUSE  5'd13
`define CP0_EPC    5'd14

// Status bits.
`define STATUS_IE  0
`define STATUS_EXL 1

// Low bit of the 8-bit mask in Status and pending field in Cause.
`define IM_LSB 8
`define IP_LSB 8

`endif
